// File: Bender.yml
package:
  name: mmc1

sources:
  - hw/mmc1_pkg.sv
  - hw/mmc1_serial_ctrl.sv
  - hw/mmc1_reg_bank.sv
  - hw/mmc1_prg_map.sv
  - hw/mmc1_chr_map.sv
  - hw/mmc1_top.sv
  - target: test
    include_dirs:
      - verification
    files:
      - verification/mmc1_tb.sv

// File: files.f
+incdir+verification
hw/mmc1_pkg.sv
hw/mmc1_serial_ctrl.sv
hw/mmc1_reg_bank.sv
hw/mmc1_prg_map.sv
hw/mmc1_chr_map.sv
hw/mmc1_top.sv
verification/mmc1_tb.sv

// File: hw/mmc1_chr_map.sv
module mmc1_chr_map import mmc1_pkg::*; #(
    parameter int ADDR_BITS = 19,
    parameter bit CHR_RAM   = 1'b0
) (
    input  ppu_addr_t            ppu_addr,
    input  logic                 ppu_rd,
    input  logic                 ppu_wr,
    input  bank_t                control,
    input  bank_t                chr_bank_0,
    input  bank_t                chr_bank_1,
    output logic [ADDR_BITS-1:0] chr_addr,
    output logic                 chr_ce,
    output logic                 chr_oe,
    output logic                 chr_we,
    output logic                 ciram_ce,
    output logic                 ciram_a10
);

    bank_t chr_sel;

    always_comb begin
        if (CHR_RAM) begin
            chr_sel = {4'b0000, ppu_addr[12]};   // plain 8 KB of ram.
        end else if (!control[4]) begin
            chr_sel = {chr_bank_0[4:1], ppu_addr[12]};
        end else begin
            chr_sel = ppu_addr[12] ? chr_bank_1 : chr_bank_0;  // two 4 KB halves.
        end
    end

    assign chr_addr = ADDR_BITS'({chr_sel, ppu_addr[11:0]});

    // pattern tables below $2000, nametables above.
    assign ciram_ce = !ppu_addr[13];
    assign chr_ce   = !ppu_addr[13];
    assign chr_oe   = !ppu_rd;
    assign chr_we   = CHR_RAM ? !ppu_wr : 1'b0;

    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    // mirroring
    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    always_comb begin
        case (control[1:0])
            2'd0:    ciram_a10 = 1'b0;          // one screen, lower.
            2'd1:    ciram_a10 = 1'b1;          // one screen, upper.
            2'd2:    ciram_a10 = ppu_addr[10];  // vertical.
            default: ciram_a10 = ppu_addr[11];  // horizontal.
        endcase
    end

endmodule

// File: hw/mmc1_pkg.sv
package mmc1_pkg;

    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    // bus widths
    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    typedef logic [15:0] cpu_addr_t;
    typedef logic [7:0]  cpu_data_t;
    typedef logic [13:0] ppu_addr_t;

    typedef logic [4:0]  bank_t;      // serial value, control, chr banks.
    typedef logic [3:0]  prg_bank_t;

    // commit target, picked by cpu_addr[14:13].
    typedef logic [1:0]  reg_sel_t;

    localparam reg_sel_t SEL_CONTROL = 2'd0;
    localparam reg_sel_t SEL_CHR0    = 2'd1;
    localparam reg_sel_t SEL_CHR1    = 2'd2;
    localparam reg_sel_t SEL_PRG     = 2'd3;

    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    // save-state port
    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    typedef logic [2:0]  sst_addr_t;
    typedef logic [7:0]  sst_data_t;

    localparam sst_addr_t SST_SHIFT   = 3'd0;
    localparam sst_addr_t SST_CONTROL = 3'd1;
    localparam sst_addr_t SST_CHR0    = 3'd2;
    localparam sst_addr_t SST_CHR1    = 3'd3;
    localparam sst_addr_t SST_PRG     = 3'd4;

    localparam sst_data_t SST_UNMAPPED = 8'hFF;  // reads of indices 5 to 7.

    // marker bit lands in bit 0 after four shifts.
    localparam bank_t SHIFT_RESET   = 5'b10000;
    localparam bank_t CONTROL_RESET = 5'b01100;  // prg mode 3, fixed last bank.

    localparam prg_bank_t PRG_LAST_BANK = 4'hF;

endpackage

// File: hw/mmc1_prg_map.sv
module mmc1_prg_map import mmc1_pkg::*; #(
    parameter int ADDR_BITS = 19
) (
    input  cpu_addr_t            cpu_addr,
    input  logic                 cpu_rw,
    input  bank_t                control,
    input  prg_bank_t            prg_bank,
    input  logic                 prg_hi,
    output logic [ADDR_BITS-1:0] prg_addr,
    output logic                 prg_oe,
    output logic                 prg_we,
    output logic                 wram_ce
);

    prg_bank_t prg_sel;   // 16 KB bank seen at the current address.

    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    // bank select
    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    always_comb begin
        case (control[3:2])
            2'b10: begin
                // $8000 fixed to the first bank.
                prg_sel = cpu_addr[14] ? prg_bank : 4'h0;
            end
            2'b11: begin
                // $C000 fixed to the last bank.
                prg_sel = cpu_addr[14] ? PRG_LAST_BANK : prg_bank;
            end
            default: begin
                prg_sel = {prg_bank[3:1], cpu_addr[14]};  // 32 KB mode.
            end
        endcase
    end

    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    // address and strobes
    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    assign wram_ce = (cpu_addr[15:13] == 3'b011);   // $6000-$7FFF.

    assign prg_addr = wram_ce ? ADDR_BITS'(cpu_addr[12:0])
                              : ADDR_BITS'({prg_hi, prg_sel, cpu_addr[13:0]});

    assign prg_oe = cpu_rw && (cpu_addr[15] || wram_ce);
    assign prg_we = !cpu_rw && wram_ce;   // only wram is writable.

endmodule

// File: hw/mmc1_reg_bank.sv
module mmc1_reg_bank import mmc1_pkg::*; (
    input  logic      m2,
    input  logic      arst_n,
    input  logic      commit,
    input  reg_sel_t  commit_sel,
    input  bank_t     commit_data,
    input  logic      ctl_force,
    input  bank_t     shift_q,
    input  logic      sst_enable,
    input  logic      sst_we,
    input  sst_addr_t sst_addr,
    input  sst_data_t sst_data_in,
    output bank_t     control,
    output bank_t     chr_bank_0,
    output bank_t     chr_bank_1,
    output prg_bank_t prg_bank,
    output sst_data_t sst_data_out
);

    logic sst_wr;

    assign sst_wr = sst_enable && sst_we;

    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    // bank registers
    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    always_ff @(negedge m2 or negedge arst_n) begin
        if (!arst_n) begin
            control    <= CONTROL_RESET;
            chr_bank_0 <= '0;
            chr_bank_1 <= '0;
            prg_bank   <= '0;
        end else if (sst_wr) begin
            case (sst_addr)
                SST_CONTROL: control    <= sst_data_in[4:0];
                SST_CHR0:    chr_bank_0 <= sst_data_in[4:0];
                SST_CHR1:    chr_bank_1 <= sst_data_in[4:0];
                SST_PRG:     prg_bank   <= sst_data_in[3:0];
                default: ;   // shift lives in the serial loader.
            endcase
        end else if (ctl_force) begin
            control <= control | CONTROL_RESET;  // back to prg mode 3.
        end else if (commit) begin
            case (commit_sel)
                SEL_CONTROL: control    <= commit_data;
                SEL_CHR0:    chr_bank_0 <= commit_data;
                SEL_CHR1:    chr_bank_1 <= commit_data;
                SEL_PRG:     prg_bank   <= commit_data[3:0];
                default: ;
            endcase
        end
    end

    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    // save-state readback
    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    always_comb begin
        case (sst_addr)
            SST_SHIFT:   sst_data_out = {3'b000, shift_q};
            SST_CONTROL: sst_data_out = {3'b000, control};
            SST_CHR0:    sst_data_out = {3'b000, chr_bank_0};
            SST_CHR1:    sst_data_out = {3'b000, chr_bank_1};
            SST_PRG:     sst_data_out = {4'b0000, prg_bank};
            default:     sst_data_out = SST_UNMAPPED;
        endcase
    end

endmodule

// File: hw/mmc1_serial_ctrl.sv
module mmc1_serial_ctrl import mmc1_pkg::*; (
    input  logic      m2,
    input  logic      arst_n,
    input  cpu_addr_t cpu_addr,
    input  cpu_data_t cpu_data_in,
    input  logic      cpu_rw,
    input  logic      sst_enable,
    input  logic      sst_we,
    input  sst_addr_t sst_addr,
    input  sst_data_t sst_data_in,
    output logic      commit,
    output reg_sel_t  commit_sel,
    output bank_t     commit_data,
    output logic      ctl_force,
    output bank_t     shift_q
);

    logic  cpu_wr;
    logic  sst_shift_wr;
    bank_t shift_next;

    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    // write decode
    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

    // save-state access blocks the cpu path entirely.
    assign cpu_wr       = cpu_addr[15] && !cpu_rw && !sst_enable;
    assign sst_shift_wr = sst_enable && sst_we && (sst_addr == SST_SHIFT);

    // lsb first, new bit enters at the top.
    assign shift_next = {cpu_data_in[0], shift_q[4:1]};

    assign ctl_force   = cpu_wr && cpu_data_in[7];
    assign commit      = cpu_wr && !cpu_data_in[7] && shift_q[0];  // fifth write.
    assign commit_sel  = cpu_addr[14:13];
    assign commit_data = shift_next;

    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    // shift register
    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    always_ff @(negedge m2 or negedge arst_n) begin
        if (!arst_n) begin
            shift_q <= SHIFT_RESET;
        end else if (sst_shift_wr) begin
            shift_q <= sst_data_in[4:0];
        end else if (ctl_force || commit) begin
            shift_q <= SHIFT_RESET;   // restart the count.
        end else if (cpu_wr) begin
            shift_q <= shift_next;
        end
    end

endmodule

// File: hw/mmc1_top.sv
module mmc1_top import mmc1_pkg::*; #(
    parameter bit CHR_RAM   = 1'b0,
    parameter int ADDR_BITS = 19
) (
    input  logic                 m2,
    input  logic                 arst_n,
    input  cpu_addr_t            cpu_addr,
    input  cpu_data_t            cpu_data_in,
    input  logic                 cpu_rw,
    input  ppu_addr_t            ppu_addr,
    input  logic                 ppu_rd,
    input  logic                 ppu_wr,
    input  logic                 sst_enable,
    input  logic                 sst_we,
    input  sst_addr_t            sst_addr,
    input  sst_data_t            sst_data_in,
    output logic [ADDR_BITS-1:0] prg_addr,
    output logic                 prg_oe,
    output logic                 prg_we,
    output logic                 wram_ce,
    output logic [ADDR_BITS-1:0] chr_addr,
    output logic                 chr_ce,
    output logic                 chr_oe,
    output logic                 chr_we,
    output logic                 ciram_ce,
    output logic                 ciram_a10,
    output sst_data_t            sst_data_out
);

    logic      commit;
    reg_sel_t  commit_sel;
    bank_t     commit_data;
    logic      ctl_force;
    bank_t     shift_q;
    bank_t     control;
    bank_t     chr_bank_0;
    bank_t     chr_bank_1;
    prg_bank_t prg_bank;

    mmc1_serial_ctrl u_serial_ctrl (
        .m2, .arst_n, .cpu_addr, .cpu_data_in, .cpu_rw,
        .sst_enable, .sst_we, .sst_addr, .sst_data_in,
        .commit, .commit_sel, .commit_data, .ctl_force, .shift_q
    );

    mmc1_reg_bank u_reg_bank (
        .m2, .arst_n, .commit, .commit_sel, .commit_data, .ctl_force, .shift_q,
        .sst_enable, .sst_we, .sst_addr, .sst_data_in,
        .control, .chr_bank_0, .chr_bank_1, .prg_bank, .sst_data_out
    );

    // chr_bank_0[4] doubles as the 256 KB prg select.
    mmc1_prg_map #(.ADDR_BITS(ADDR_BITS)) u_prg_map (
        .cpu_addr, .cpu_rw, .control, .prg_bank, .prg_hi(chr_bank_0[4]),
        .prg_addr, .prg_oe, .prg_we, .wram_ce
    );

    mmc1_chr_map #(.ADDR_BITS(ADDR_BITS), .CHR_RAM(CHR_RAM)) u_chr_map (
        .ppu_addr, .ppu_rd, .ppu_wr, .control, .chr_bank_0, .chr_bank_1,
        .chr_addr, .chr_ce, .chr_oe, .chr_we, .ciram_ce, .ciram_a10
    );

endmodule

// File: verification/mmc1_model.svh
`ifndef MMC1_MODEL_SVH
`define MMC1_MODEL_SVH

// register copies, updated on each falling edge of m2.
bank_t     m_shift;
bank_t     m_control;
bank_t     m_chr0;
bank_t     m_chr1;
prg_bank_t m_prg;

function automatic void init_state();
    m_shift   = 5'b10000;   // marker bit only.
    m_control = 5'b01100;
    m_chr0    = '0;
    m_chr1    = '0;
    m_prg     = '0;
endfunction

function automatic void apply_edge(input cpu_addr_t a, input cpu_data_t d, input logic rw,
                                   input logic s_en, input logic s_we,
                                   input sst_addr_t s_idx, input sst_data_t s_d);
    bank_t full;
    full = {d[0], m_shift[4:1]};
    if (s_en) begin
        if (s_we) begin
            case (s_idx)
                3'd0: m_shift   = s_d[4:0];
                3'd1: m_control = s_d[4:0];
                3'd2: m_chr0    = s_d[4:0];
                3'd3: m_chr1    = s_d[4:0];
                3'd4: m_prg     = s_d[3:0];
                default: ;
            endcase
        end
    end else if (a[15] && !rw) begin
        if (d[7]) begin
            m_shift   = 5'b10000;
            m_control = m_control | 5'b01100;
        end else if (m_shift[0]) begin
            case (a[14:13])   // fifth bit completes the value.
                2'd0: m_control = full;
                2'd1: m_chr0    = full;
                2'd2: m_chr1    = full;
                default: m_prg  = full[3:0];
            endcase
            m_shift = 5'b10000;
        end else begin
            m_shift = full;
        end
    end
endfunction

function automatic sst_data_t saved_value(input sst_addr_t idx);
    case (idx)
        3'd0: return {3'b000, m_shift};
        3'd1: return {3'b000, m_control};
        3'd2: return {3'b000, m_chr0};
        3'd3: return {3'b000, m_chr1};
        3'd4: return {4'b0000, m_prg};
        default: return 8'hFF;
    endcase
endfunction

function automatic logic [18:0] prg_target(input cpu_addr_t a);
    prg_bank_t bank;
    if (a >= 16'h6000 && a < 16'h8000) begin
        return {6'b000000, a[12:0]};
    end
    if (m_control[3] == 1'b0) begin
        bank = (m_prg & 4'hE) | {3'b000, a[14]};
    end else if (m_control[2] == 1'b0) begin
        bank = a[14] ? m_prg : 4'h0;
    end else begin
        bank = a[14] ? 4'hF : m_prg;
    end
    return {m_chr0[4], bank, a[13:0]};
endfunction

function automatic logic [18:0] chr_target(input ppu_addr_t p);
    bank_t bank;
    if (m_control[4]) begin
        bank = p[12] ? m_chr1 : m_chr0;
    end else begin
        bank = {m_chr0[4:1], p[12]};
    end
    return {2'b00, bank, p[11:0]};
endfunction

function automatic logic mirror_bit(input ppu_addr_t p);
    case (m_control[1:0])
        2'd0: return 1'b0;
        2'd1: return 1'b1;
        2'd2: return p[10];
        default: return p[11];
    endcase
endfunction

`endif

// File: verification/mmc1_tb.sv
module mmc1_tb import mmc1_pkg::*; ();

    localparam int N_SEQ   = 32;
    localparam int N_FORCE = 16;
    localparam int N_ROUND = 24;
    localparam int N_SAVE  = 32;
    localparam int TOTAL_CYCLES = 3 + 9 + N_SEQ * 8 + N_FORCE * 8 + 2 * N_ROUND * 11
                                + N_SAVE * 3;

    logic        m2;
    logic        arst_n;
    cpu_addr_t   cpu_addr;
    cpu_data_t   cpu_data_in;
    logic        cpu_rw;
    ppu_addr_t   ppu_addr;
    logic        ppu_rd;
    logic        ppu_wr;
    logic        sst_enable;
    logic        sst_we;
    sst_addr_t   sst_addr;
    sst_data_t   sst_data_in;
    logic [18:0] prg_addr;
    logic        prg_oe;
    logic        prg_we;
    logic        wram_ce;
    logic [18:0] chr_addr;
    logic        chr_ce;
    logic        chr_oe;
    logic        chr_we;
    logic        ciram_ce;
    logic        ciram_a10;
    sst_data_t   sst_data_out;

    integer seed = 32'h72fc_ada9;
    int     errors;
    int     test_errors;
    int     passed;
    int     failed;
    string  test_name;

    `include "mmc1_model.svh"

    mmc1_top #(.CHR_RAM(1'b0), .ADDR_BITS(19)) UUT (.*);

    always #20 m2 = ~m2;

    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    // bus cycles and checks
    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    task automatic report_mismatch(input string what, input int unsigned exp,
                                   input int unsigned act);
        errors++;
        test_errors++;
        $display("[ERROR] %s %s: expected 0x%0h, actual 0x%0h", test_name, what, exp, act);
    endtask

    task automatic end_test();
        if (test_errors == 0) begin
            passed++;
            $display("test %s: pass", test_name);
        end else begin
            failed++;
            $display("test %s: fail, %0d mismatches", test_name, test_errors);
        end
        test_errors = 0;
    endtask

    // one m2 period; outputs are settled 10 units after the falling edge.
    task automatic bus_cycle(input cpu_addr_t a, input cpu_data_t d, input logic rw,
                             input logic s_en, input logic s_we, input sst_addr_t s_idx,
                             input sst_data_t s_d);
        @(posedge m2);
        #5;
        cpu_addr    = a;
        cpu_data_in = d;
        cpu_rw      = rw;
        sst_enable  = s_en;
        sst_we      = s_we;
        sst_addr    = s_idx;
        sst_data_in = s_d;
        ppu_addr    = ppu_addr_t'($random(seed));
        ppu_rd      = $random(seed);
        ppu_wr      = $random(seed);
        @(negedge m2);
        #10;
        apply_edge(a, d, rw, s_en, s_we, s_idx, s_d);
    endtask

    task automatic read_reg(input sst_addr_t idx);
        bus_cycle(cpu_addr_t'($random(seed)), 8'h00, 1'b1, 1'b0, 1'b0, idx, 8'h00);
        if (sst_data_out !== saved_value(idx))
            report_mismatch($sformatf("sst[%0d]", idx), saved_value(idx), sst_data_out);
    endtask

    // a cpu write rides along and must lose to the save-state write.
    task automatic write_reg(input sst_addr_t idx, input sst_data_t val);
        bus_cycle(cpu_addr_t'($random(seed)) | 16'h8000, cpu_data_t'($random(seed)), 1'b0,
                  1'b1, 1'b1, idx, val);
    endtask

    task automatic check_maps();
        logic wram;
        wram = (cpu_addr >= 16'h6000) && (cpu_addr < 16'h8000);
        if (prg_addr !== prg_target(cpu_addr))
            report_mismatch("prg_addr", prg_target(cpu_addr), prg_addr);
        if (prg_oe !== (cpu_rw && (cpu_addr[15] || wram)))
            report_mismatch("prg_oe", cpu_rw && (cpu_addr[15] || wram), prg_oe);
        if (prg_we !== (!cpu_rw && wram))
            report_mismatch("prg_we", !cpu_rw && wram, prg_we);
        if (wram_ce !== wram)
            report_mismatch("wram_ce", wram, wram_ce);
        if (chr_addr !== chr_target(ppu_addr))
            report_mismatch("chr_addr", chr_target(ppu_addr), chr_addr);
        if (chr_ce !== !ppu_addr[13])
            report_mismatch("chr_ce", !ppu_addr[13], chr_ce);
        if (ciram_ce !== !ppu_addr[13])
            report_mismatch("ciram_ce", !ppu_addr[13], ciram_ce);
        if (chr_oe !== !ppu_rd)
            report_mismatch("chr_oe", !ppu_rd, chr_oe);
        if (chr_we !== 1'b0)
            report_mismatch("chr_we", 0, chr_we);   // rom board.
        if (ciram_a10 !== mirror_bit(ppu_addr))
            report_mismatch("ciram_a10", mirror_bit(ppu_addr), ciram_a10);
    endtask

    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    // test sequence
    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    initial begin
        cpu_addr_t a;
        cpu_data_t d;
        logic      rw;
        sst_addr_t idx;
        sst_data_t val;
        int        k;
        m2          = 1'b0;
        arst_n      = 1'b1;
        cpu_addr    = '0;
        cpu_data_in = '0;
        cpu_rw      = 1'b1;
        ppu_addr    = '0;
        ppu_rd      = 1'b1;
        ppu_wr      = 1'b1;
        sst_enable  = 1'b0;
        sst_we      = 1'b0;
        sst_addr    = '0;
        sst_data_in = '0;
        errors      = 0;
        test_errors = 0;
        passed      = 0;
        failed      = 0;
        init_state();
        #1;
        arst_n = 1'b0;
        repeat (2) @(posedge m2);
        #5;
        arst_n = 1'b1;

        test_name = "reset";
        for (int i = 0; i < 8; i++) read_reg(sst_addr_t'(i));
        bus_cycle(16'hC000, 8'h00, 1'b1, 1'b0, 1'b0, 3'd0, 8'h00);
        check_maps();
        if (prg_addr[17:14] !== 4'hF) report_mismatch("bank at $C000", 4'hF, prg_addr[17:14]);
        end_test();

        test_name = "serial_commit";
        for (int s = 0; s < N_SEQ; s++) begin
            k = {$random(seed)} % 5;
            for (int w = 0; w < 5; w++) begin
                if (w == k) begin   // reads and low writes leave the loader alone.
                    bus_cycle(cpu_addr_t'($random(seed)) | 16'h8000, 8'h01, 1'b1,
                              1'b0, 1'b0, 3'd0, 8'h00);
                    bus_cycle(cpu_addr_t'($random(seed)) & 16'h7FFF, 8'h01, 1'b0,
                              1'b0, 1'b0, 3'd0, 8'h00);
                end
                a = cpu_addr_t'($random(seed)) | 16'h8000;
                d = cpu_data_t'($random(seed)) & 8'h7F;
                bus_cycle(a, d, 1'b0, 1'b0, 1'b0, 3'd0, 8'h00);
            end
            read_reg(sst_addr_t'(a[14:13]) + 3'd1);
        end
        end_test();

        test_name = "serial_reset";
        for (int s = 0; s < N_FORCE; s++) begin
            // prg mode 0 or 1 first, so the force has bits to set.
            write_reg(3'd1, sst_data_t'($random(seed)) & 8'hF3);
            k = {$random(seed)} % 5;
            for (int w = 0; w < k; w++) begin
                bus_cycle(cpu_addr_t'($random(seed)) | 16'h8000,
                          cpu_data_t'($random(seed)) & 8'h7F, 1'b0, 1'b0, 1'b0, 3'd0, 8'h00);
            end
            bus_cycle(cpu_addr_t'($random(seed)) | 16'h8000, cpu_data_t'($random(seed)) | 8'h80,
                      1'b0, 1'b0, 1'b0, 3'd0, 8'h00);
            read_reg(3'd0);
            if (sst_data_out !== 8'h10) report_mismatch("shift", 8'h10, sst_data_out);
            read_reg(3'd1);
            if (sst_data_out[3:2] !== 2'b11)
                report_mismatch("control[3:2]", 2'b11, sst_data_out[3:2]);
        end
        end_test();

        test_name = "prg_map";
        for (int r = 0; r < N_ROUND; r++) begin
            val = sst_data_t'($random(seed));
            val[3:2] = r[1:0];   // walk all prg modes.
            write_reg(3'd1, val);
            write_reg(3'd4, sst_data_t'($random(seed)));
            write_reg(3'd2, sst_data_t'($random(seed)));
            for (int c = 0; c < 8; c++) begin
                a = cpu_addr_t'($random(seed));
                rw = a[15] ? 1'b1 : 1'($random(seed));
                bus_cycle(a, cpu_data_t'($random(seed)), rw, 1'b0, 1'b0, 3'd0, 8'h00);
                check_maps();
            end
        end
        end_test();

        test_name = "chr_map";
        for (int r = 0; r < N_ROUND; r++) begin
            val = sst_data_t'($random(seed));
            val[4]   = r[2];
            val[1:0] = r[1:0];
            write_reg(3'd1, val);
            write_reg(3'd2, sst_data_t'($random(seed)));
            write_reg(3'd3, sst_data_t'($random(seed)));
            for (int c = 0; c < 8; c++) begin
                bus_cycle(cpu_addr_t'($random(seed)), 8'h00, 1'b1, 1'b0, 1'b0, 3'd0, 8'h00);
                check_maps();
            end
        end
        end_test();

        test_name = "save_state";
        for (int s = 0; s < N_SAVE; s++) begin
            idx = sst_addr_t'({$random(seed)} % 5);
            val = sst_data_t'($random(seed));
            write_reg(idx, val);
            read_reg(idx);
            d = val & ((idx == 3'd4) ? 8'h0F : 8'h1F);
            if (sst_data_out !== d) report_mismatch("readback", d, sst_data_out);
            read_reg(3'd0);   // the ignored cpu write must not move the loader.
        end
        end_test();

        $display("summary: %0d tests passed, %0d failed, %0d mismatches", passed, failed, errors);
        if (errors == 0) begin
            $display("ALL CHECKS PASSED");
        end else begin
            $display("CHECKS FAILED");
        end
        $finish;
    end

    initial begin
        #((TOTAL_CYCLES + 50) * 40);
        $display("watchdog: run did not finish within %0d cycles", TOTAL_CYCLES + 50);
        $display("CHECKS FAILED");
        $finish;
    end

endmodule
